/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] word_t;                  // data and address word
    typedef logic [4:0]  reg_idx_t;               // x0..x31

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,                  // register-register alu
        OPC_OP_IMM = 7'b0010011,                  // register-immediate alu
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_LOAD   = 7'b0000011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011                   // ecall and ebreak
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;                          // imm[11:0]
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;                       // imm[11:5]
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                       // imm[4:0]
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;                          // imm[31:12]
        reg_idx_t    rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

/* hdl/exec_pkg.sv */
package exec_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        instr_u instr;
        word_t  pc;
    } fetch_t;

    typedef enum logic [2:0] {
        CLS_NONE, CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_SYSTEM
    } instr_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_e;
    typedef enum logic       {OPB_RS2, OPB_IMM} opb_sel_e;

    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;
        opa_sel_e     opa_sel;
        opb_sel_e     opb_sel;
        reg_idx_t     rd;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        logic [2:0]   funct3;
        word_t        imm;                         // already sign extended
        word_t        pc;
    } decoded_t;

    typedef struct packed {
        logic        re;
        logic [3:0]  we;                           // byte lane strobes
        logic [29:0] idx;                          // word index, addr[31:2]
        word_t       wdata;
        logic [2:0]  funct3;                       // load kind
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

/* hdl/fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode import rv_isa_pkg::*, exec_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic     clk,
    input  logic     rst_n,
    input  fetch_t   fetch_i,
    input  logic     advance_i,
    output decoded_t dec_o
);

    fetch_t f_q;                                   // instruction under execution
    instr_u in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            f_q.instr <= NOP_INSTR;                // start on a harmless nop
            f_q.pc    <= RESET_PC;
        end else if (advance_i) begin
            f_q <= fetch_i;                        // load on retire
        end
    end

    assign in = f_q.instr;

    always_comb begin
        dec_o         = '0;
        dec_o.cls     = CLS_NONE;                  // unknown opcodes just pass
        dec_o.alu_op  = ALU_PASS_B;
        dec_o.opa_sel = OPA_ZERO;
        dec_o.opb_sel = OPB_IMM;
        dec_o.rd      = in.r.rd;                   // fields share their slots
        dec_o.rs1     = in.r.rs1;
        dec_o.rs2     = in.r.rs2;
        dec_o.funct3  = in.r.funct3;
        dec_o.pc      = f_q.pc;
        dec_o.imm     = {{20{in.i.imm[11]}}, in.i.imm};   // i form by default
        case (in.r.opcode)
            OPC_OP, OPC_OP_IMM: begin
                dec_o.cls     = CLS_ALU;
                dec_o.opa_sel = OPA_RS1;
                dec_o.opb_sel = (in.r.opcode == OPC_OP) ? OPB_RS2 : OPB_IMM;
                case (in.r.funct3)
                    3'b000: dec_o.alu_op = (in.r.opcode == OPC_OP && in.r.funct7[5]) ?
                                           ALU_SUB : ALU_ADD;  // no subi
                    3'b001: dec_o.alu_op = ALU_SLL;
                    3'b010: dec_o.alu_op = ALU_SLT;
                    3'b011: dec_o.alu_op = ALU_SLTU;
                    3'b100: dec_o.alu_op = ALU_XOR;
                    3'b101: dec_o.alu_op = in.r.funct7[5] ? ALU_SRA : ALU_SRL; // bit 30
                    3'b110: dec_o.alu_op = ALU_OR;
                    default: dec_o.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                dec_o.cls = CLS_ALU;
                dec_o.imm = {in.u.imm, 12'b0};     // upper immediate straight through
            end
            OPC_AUIPC: begin
                dec_o.cls     = CLS_ALU;
                dec_o.alu_op  = ALU_ADD;
                dec_o.opa_sel = OPA_PC;
                dec_o.imm     = {in.u.imm, 12'b0};
            end
            OPC_STORE: begin
                dec_o.cls = CLS_STORE;
                dec_o.imm = {{20{in.s.imm_hi[6]}}, in.s.imm_hi, in.s.imm_lo};
            end
            OPC_LOAD:   dec_o.cls = CLS_LOAD;      // i form offset
            OPC_JALR:   dec_o.cls = CLS_JALR;
            OPC_JAL: begin
                dec_o.cls = CLS_JAL;
                dec_o.imm = {{11{in.j.imm20}}, in.j.imm20, in.j.imm19_12,
                             in.j.imm11, in.j.imm10_1, 1'b0};
            end
            OPC_BRANCH: begin
                dec_o.cls = CLS_BRANCH;
                dec_o.imm = {{19{in.b.imm12}}, in.b.imm12, in.b.imm11,
                             in.b.imm10_5, in.b.imm4_1, 1'b0};
            end
            OPC_SYSTEM: dec_o.cls = CLS_SYSTEM;    // ecall and ebreak alike
            default: ;
        endcase
    end

    // pc handed over by the fetch side lands aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        advance_i |=> f_q.pc[1:0] == 2'b00);

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*, exec_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  wb_t      wb_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);

    word_t regs [1:31];                            // x0 has no storage

    always_ff @(posedge clk) begin
        if (wb_i.valid && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;            // write on retire
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];   // x0 reads zero
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    // writeback side already drops rd == 0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_i.valid |-> wb_i.rd != '0);

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu import rv_isa_pkg::*, exec_pkg::*; (
    input  decoded_t dec_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    output word_t    result_o
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    always_comb begin
        case (dec_i.opa_sel)
            OPA_RS1: op_a = rs1_data_i;
            OPA_PC:  op_a = dec_i.pc;              // auipc
            default: op_a = '0;
        endcase
    end

    assign op_b  = (dec_i.opb_sel == OPB_RS2) ? rs2_data_i : dec_i.imm;
    assign shamt = op_b[4:0];                      // low five bits only

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    result_o = op_a + op_b;
            ALU_SUB:    result_o = op_a - op_b;
            ALU_SLL:    result_o = op_a << shamt;
            ALU_SLT:    result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result_o = {31'b0, op_a < op_b};
            ALU_XOR:    result_o = op_a ^ op_b;
            ALU_SRL:    result_o = op_a >> shamt;
            ALU_SRA:    result_o = word_t'($signed(op_a) >>> shamt);   // keeps sign
            ALU_OR:     result_o = op_a | op_b;
            ALU_AND:    result_o = op_a & op_b;
            ALU_PASS_B: result_o = op_b;           // lui
            default:    result_o = '0;
        endcase
    end

endmodule

/* hdl/data_mem.sv */
`timescale 1ns/1ps

module data_mem import rv_isa_pkg::*, exec_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  logic     clk,
    input  mem_req_t req_i,
    output word_t    load_data_o
);

    localparam int AW = $clog2(MEM_WORDS);

    word_t          mem [MEM_WORDS];
    word_t          rd_q;                          // registered read word
    logic [2:0]     kind_q;                        // load kind held with it
    logic [AW-1:0]  idx;

    assign idx = req_i.idx[AW-1:0];                // upper address bits wrap

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (req_i.we[b]) begin
                mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];   // per lane
            end
        end
        if (req_i.re) begin
            rd_q   <= mem[idx];
            kind_q <= req_i.funct3;
        end
    end

    always_comb begin
        case (kind_q)
            3'b000:  load_data_o = {{24{rd_q[7]}}, rd_q[7:0]};     // lb
            3'b001:  load_data_o = {{16{rd_q[15]}}, rd_q[15:0]};   // lh
            3'b100:  load_data_o = {24'b0, rd_q[7:0]};             // lbu
            3'b101:  load_data_o = {16'b0, rd_q[15:0]};            // lhu
            default: load_data_o = rd_q;                           // lw
        endcase
    end

    // loads and stores never share a cycle
    a_rw_exclusive: assert property (@(posedge clk) !(req_i.re && |req_i.we));

endmodule

/* hdl/exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl import rv_isa_pkg::*, exec_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     valid_i,
    input  decoded_t dec_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    input  word_t    alu_result_i,
    input  word_t    load_data_i,
    output logic     advance_o,
    output logic     jump_o,
    output word_t    target_pc_o,
    output mem_req_t mem_req_o,
    output wb_t      wb_o,
    output logic     halted_o
);

    logic  waited_q;                               // advance was low last cycle
    logic  taken;
    logic  redirect;                               // jal, jalr or taken branch
    logic  two_cycle;
    logic  writes_rd;
    word_t addr;
    word_t link;

    always_comb begin
        case (dec_i.funct3)
            3'b000:  taken = rs1_data_i == rs2_data_i;                    // beq
            3'b001:  taken = rs1_data_i != rs2_data_i;                    // bne
            3'b100:  taken = $signed(rs1_data_i) <  $signed(rs2_data_i);  // blt
            3'b101:  taken = $signed(rs1_data_i) >= $signed(rs2_data_i);  // bge
            3'b110:  taken = rs1_data_i <  rs2_data_i;                    // bltu
            3'b111:  taken = rs1_data_i >= rs2_data_i;                    // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign redirect  = dec_i.cls == CLS_JAL || dec_i.cls == CLS_JALR ||
                       (dec_i.cls == CLS_BRANCH && taken);
    assign two_cycle = redirect || dec_i.cls == CLS_LOAD;
    assign advance_o = valid_i && (!two_cycle || waited_q);  // second pass retires
    assign jump_o    = redirect && !waited_q;                // one pulse per jump

    assign target_pc_o = (dec_i.cls == CLS_JALR) ? rs1_data_i + dec_i.imm
                                                 : dec_i.pc + dec_i.imm;
    assign link = dec_i.pc + 32'd4;
    assign addr = rs1_data_i + dec_i.imm;                    // load and store address

    always_comb begin
        mem_req_o        = '0;
        mem_req_o.idx    = addr[31:2];             // byte offset ignored
        mem_req_o.wdata  = rs2_data_i;             // low lanes carry sb and sh
        mem_req_o.funct3 = dec_i.funct3;
        mem_req_o.re     = dec_i.cls == CLS_LOAD && !waited_q;   // first cycle only
        if (dec_i.cls == CLS_STORE && advance_o) begin
            case (dec_i.funct3[1:0])
                2'b00:   mem_req_o.we = 4'b0001;   // sb
                2'b01:   mem_req_o.we = 4'b0011;   // sh
                default: mem_req_o.we = 4'b1111;   // sw
            endcase
        end
    end

    assign writes_rd = dec_i.cls == CLS_ALU || dec_i.cls == CLS_LOAD ||
                       dec_i.cls == CLS_JAL || dec_i.cls == CLS_JALR;

    always_comb begin
        wb_o.valid = advance_o && writes_rd && dec_i.rd != '0;   // x0 writes dropped
        wb_o.rd    = dec_i.rd;
        case (dec_i.cls)
            CLS_LOAD:          wb_o.data = load_data_i;
            CLS_JAL, CLS_JALR: wb_o.data = link;
            default:           wb_o.data = alu_result_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waited_q <= 1'b0;
            halted_o <= 1'b0;
        end else begin
            waited_q <= !advance_o;                // stall or first half of two
            if (advance_o && dec_i.cls == CLS_SYSTEM) begin
                halted_o <= 1'b1;                  // sticky until reset
            end
        end
    end

    a_jump_not_retire: assert property (@(posedge clk) disable iff (!rst_n)
        jump_o |-> !advance_o);

endmodule

/* hdl/exec_top.sv */
`timescale 1ns/1ps

module exec_top import rv_isa_pkg::*, exec_pkg::*; #(
    parameter int    MEM_WORDS = 1024,
    parameter word_t RESET_PC  = 32'h0000_0000
) (
    input  logic   clk,
    input  logic   rst_n,
    input  fetch_t fetch_i,
    input  logic   valid_i,
    output logic   advance_o,
    output logic   jump_o,
    output word_t  target_pc_o,
    output wb_t    wb_o,
    output logic   halted_o
);

    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    word_t    load_data;
    mem_req_t mem_req;

    fetch_decode #(.RESET_PC(RESET_PC)) i_fetch_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch_i  (fetch_i),
        .advance_i(advance_o),                     // retire loads the next one
        .dec_o    (dec)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_i     (dec.rs1),
        .rs2_i     (dec.rs2),
        .wb_i      (wb_o),                         // same bus that leaves the stage
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

    alu i_alu (
        .dec_i     (dec),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .result_o  (alu_result)
    );

    data_mem #(.MEM_WORDS(MEM_WORDS)) i_data_mem (
        .clk        (clk),
        .req_i      (mem_req),
        .load_data_o(load_data)
    );

    exec_ctrl i_exec_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .dec_i       (dec),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .alu_result_i(alu_result),
        .load_data_i (load_data),
        .advance_o   (advance_o),
        .jump_o      (jump_o),
        .target_pc_o (target_pc_o),
        .mem_req_o   (mem_req),
        .wb_o        (wb_o),
        .halted_o    (halted_o)
    );

endmodule

/* verification/tb_exec.sv */
`timescale 1ns/1ps

module tb_exec import rv_isa_pkg::*, exec_pkg::*; ();

    localparam int    MEM_WORDS = 1024;
    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam int    NUM_TESTS = 6;

    typedef struct packed {
        wb_t         wb;
        logic        jmp;
        word_t       tgt;
        logic [3:0]  we;
        logic [9:0]  idx;                          // word index inside the ram
        word_t       wdata;
        logic        sys;
        logic        two;                          // load or redirect, retires on second pass
    } exp_t;

    logic   clk;
    logic   rst_n;
    fetch_t fetch_i;
    logic   valid_i;
    logic   advance_o;
    logic   jump_o;
    word_t  target_pc_o;
    wb_t    wb_o;
    logic   halted_o;

    fetch_t prog [$];                              // program in fetch order
    int     tid [$];                               // test index per instruction
    word_t  pc_next = 32'h4;
    word_t  regs_m [32];                           // model register file
    word_t  mem_m [MEM_WORDS];                     // model data ram
    logic   exp_halted = 1'b0;
    logic [31:0] lfsr = 32'hc179;
    int     retired = 0;                           // includes the reset nop
    int     jumps = 0;
    int     checks = 0;
    int     err_total = 0;
    int     errs [NUM_TESTS] = '{default: 0};
    int     limit = 0;
    logic   finished = 1'b0;
    string  test_name [NUM_TESTS] = '{"alu", "load_store", "branch_jump", "stall", "x0",
                                      "ecall"};

    exec_top #(.MEM_WORDS(MEM_WORDS), .RESET_PC(RESET_PC)) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_i    (fetch_i),
        .valid_i    (valid_i),
        .advance_o  (advance_o),
        .jump_o     (jump_o),
        .target_pc_o(target_pc_o),
        .wb_o       (wb_o),
        .halted_o   (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hb4bc_d35c : lfsr >> 1;   // galois step
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input word_t w, input int t);
        prog.push_back({w, pc_next});
        tid.push_back(t);
        pc_next += 32'd4;
    endtask

    task automatic load_reg(input logic [4:0] r, input word_t v, input int t);
        word_t h;
        h = v + 32'h800;                           // addi sign extends the low part
        emit({h[31:12], r, 7'h37}, t);
        emit(enc_i(v[11:0], r, 3'd0, r, 7'h13), t);
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic exp_t exec_ref(input fetch_t f);
        word_t      w;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      addr;
        word_t      ld;
        logic [2:0] f3;
        logic [4:0] rd;
        logic       wr;
        logic       tk;
        exp_t       e;
        w     = f.instr;
        f3    = w[14:12];
        rd    = w[11:7];
        a     = regs_m[w[19:15]];
        b     = regs_m[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        e     = '0;
        wr    = 1'b0;
        case (w[6:0])
            7'h33: begin
                wr = 1'b1;
                e.wb.data = alu_ref(f3, w[30], a, b);
            end
            7'h13: begin
                wr = 1'b1;
                e.wb.data = alu_ref(f3, f3 == 3'd5 && w[30], a, imm_i);   // only srai uses bit 30
            end
            7'h37: begin
                wr = 1'b1;
                e.wb.data = {w[31:12], 12'b0};
            end
            7'h17: begin
                wr = 1'b1;
                e.wb.data = f.pc + {w[31:12], 12'b0};
            end
            7'h23: begin
                addr    = a + {{20{w[31]}}, w[31:25], w[11:7]};
                e.idx   = addr[11:2];              // byte offset has no effect
                e.wdata = b;
                e.we    = (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
            end
            7'h03: begin
                wr   = 1'b1;
                addr = a + imm_i;
                ld   = mem_m[addr[11:2]];
                case (f3)
                    3'd0:    e.wb.data = {{24{ld[7]}}, ld[7:0]};
                    3'd1:    e.wb.data = {{16{ld[15]}}, ld[15:0]};
                    3'd4:    e.wb.data = {24'b0, ld[7:0]};
                    3'd5:    e.wb.data = {16'b0, ld[15:0]};
                    default: e.wb.data = ld;
                endcase
            end
            7'h6f: begin
                wr        = 1'b1;
                e.jmp     = 1'b1;
                e.tgt     = f.pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                e.wb.data = f.pc + 32'd4;          // link
            end
            7'h67: begin
                wr        = 1'b1;
                e.jmp     = 1'b1;
                e.tgt     = a + imm_i;
                e.wb.data = f.pc + 32'd4;
            end
            7'h63: begin
                case (f3)
                    3'd0:    tk = a == b;
                    3'd1:    tk = a != b;
                    3'd4:    tk = $signed(a) < $signed(b);
                    3'd5:    tk = $signed(a) >= $signed(b);
                    3'd6:    tk = a < b;
                    3'd7:    tk = a >= b;          // unsigned ge
                    default: tk = 1'b0;
                endcase
                e.jmp = tk;
                e.tgt = f.pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            7'h73:   e.sys = 1'b1;
            default: ;
        endcase
        e.wb.valid = wr && rd != 5'd0;             // x0 never written
        e.wb.rd    = rd;
        e.two      = e.jmp || w[6:0] == 7'h03;
        return e;
    endfunction

    task automatic commit(input exp_t e);
        for (int b = 0; b < 4; b++) begin
            if (e.we[b]) mem_m[e.idx][8*b +: 8] = e.wdata[8*b +: 8];
        end
        if (e.wb.valid) regs_m[e.wb.rd] = e.wb.data;
        if (e.sys) exp_halted = 1'b1;              // sticky
    endtask

    task automatic report_value(input int t, input string what, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        $display("FAILED %s: %s expected %h actual %h", test_name[t], what, exp_v, act_v);
        errs[t]++;
        err_total++;
    endtask

    task automatic build_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [7:0]  kw;
        int          ld_f3 [5] = '{0, 1, 2, 4, 5};
        int          br_f3 [6] = '{0, 1, 4, 5, 6, 7};
        for (int r = 1; r < 16; r++) load_reg(r[4:0], rand_bits(32), 0);
        repeat (24) begin
            rd  = (rand_bits(4) == 0) ? 5'd1 : {1'b0, lfsr[3:0]};
            rs1 = (rand_bits(4) == 0) ? 5'd2 : {1'b0, lfsr[3:0]};
            rs2 = (rand_bits(4) == 0) ? 5'd3 : {1'b0, lfsr[3:0]};
            f3  = 3'(rand_bits(3));
            case (rand_bits(2))
                0: emit(enc_r((f3 == 0 || f3 == 5) && rand_bits(1) ? 7'h20 : 7'h0,
                              rs2, rs1, f3, rd), 0);
                1: begin
                    imm = 12'(rand_bits(12));
                    if (f3 == 3'd1) imm = {7'h0, imm[4:0]};
                    if (f3 == 3'd5) imm = {rand_bits(1) ? 7'h20 : 7'h0, imm[4:0]};
                    emit(enc_i(imm, rs1, f3, rd, 7'h13), 0);
                end
                2: emit({20'(rand_bits(20)), rd, 7'h37}, 0);
                default: emit({20'(rand_bits(20)), rd, 7'h17}, 0);
            endcase
        end
        for (int k = 0; k < 4; k++) begin
            kw = 8'(rand_bits(8));
            load_reg(5'd20, rand_bits(32), 1);
            emit(enc_s({2'b0, kw, 2'(rand_bits(2))}, 5'd20, 5'd0, 3'd2), 1);
            load_reg(5'd21, rand_bits(32), 1);
            emit(enc_s({2'b0, kw, 2'(rand_bits(2))}, 5'd21, 5'd0, k[0] ? 3'd1 : 3'd0), 1);
            for (int j = 0; j < 5; j++) begin
                emit(enc_i({2'b0, kw, 2'(rand_bits(2))}, 5'd0, 3'(ld_f3[j]),
                           5'(22 + j), 7'h03), 1);
            end
        end
        load_reg(5'd1, rand_bits(32), 2);
        load_reg(5'd2, rand_bits(32), 2);
        for (int p = 0; p < 3; p++) begin
            for (int j = 0; j < 6; j++) begin
                emit(enc_b({12'(rand_bits(12)), 1'b0}, (p == 0) ? 5'd2 : 5'd1,
                           (p == 1) ? 5'd2 : 5'd1, 3'(br_f3[j])), 2);
            end
        end
        emit(enc_j({20'(rand_bits(20)), 1'b0}, 5'd5), 2);
        emit(enc_i(12'(rand_bits(12)), 5'd1, 3'd0, 5'd6, 7'h67), 2);
        kw = 8'(rand_bits(8));
        load_reg(5'd7, rand_bits(32), 3);
        emit(enc_s({2'b0, kw, 2'b0}, 5'd7, 5'd0, 3'd2), 3);
        repeat (3) begin
            emit(enc_i({2'b0, kw, 2'b0}, 5'd0, 3'd2, 5'd8, 7'h03), 3);
            emit(enc_j({20'(rand_bits(20)), 1'b0}, 5'd9), 3);
            emit(enc_b({12'(rand_bits(12)), 1'b0}, 5'd0, 5'd0, 3'd0), 3);   // always taken
            emit(enc_i(12'(rand_bits(12)), 5'd7, 3'd0, 5'd10, 7'h67), 3);
        end
        emit(enc_i(12'(rand_bits(12)), 5'd1, 3'd0, 5'd0, 7'h13), 4);
        emit(enc_r(7'h0, 5'd2, 5'd1, 3'd0, 5'd0), 4);
        emit({20'(rand_bits(20)), 5'd0, 7'h37}, 4);
        emit(enc_i(12'h0, 5'd0, 3'd2, 5'd0, 7'h03), 4);
        emit(enc_j({20'(rand_bits(20)), 1'b0}, 5'd0), 4);
        emit(enc_r(7'h0, 5'd0, 5'd0, 3'd6, 5'd11), 4);   // or x11, x0, x0
        emit(enc_r(7'h0, 5'd1, 5'd0, 3'd0, 5'd12), 4);
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd13, 7'h13), 5);
        emit(32'h0000_0073, 5);                    // ecall
        emit(enc_i(12'd6, 5'd0, 3'd0, 5'd14, 7'h13), 5);
        emit(32'h0010_0073, 5);                    // ebreak
        emit(enc_i(12'd7, 5'd0, 3'd0, 5'd15, 7'h13), 5);
    endtask

    // next instruction ready whenever the current one may retire
    always @(negedge clk) begin
        fetch_i <= (retired < prog.size()) ? prog[retired] : {NOP_INSTR, 32'h0};
        valid_i <= retired <= prog.size() &&
                   !(retired > 0 && tid[retired-1] == 3 && rand_bits(2) == 0);
    end

    initial begin : compare
        exp_t   e;
        fetch_t cur;
        int     t;
        logic   wb_ok;
        logic   exp_adv;
        logic   waited_m;
        @(posedge rst_n);
        waited_m = 1'b0;                           // stage leaves reset not waiting
        while (!finished) begin
            #4;                                    // settled, 1 ns ahead of the rising edge
            cur = (retired == 0) ? {NOP_INSTR, RESET_PC} : prog[retired-1];
            t   = (retired == 0) ? 0 : tid[retired-1];
            e   = exec_ref(cur);
            exp_adv = valid_i && (!e.two || waited_m);   // two-cycle ones retire on second pass
            checks += 2;
            assert (halted_o === exp_halted)
                else report_value(t, "halted_o", exp_halted, halted_o);
            assert (advance_o === exp_adv)
                else report_value(t, "advance_o", exp_adv, advance_o);
            if (jump_o) begin
                jumps++;
                checks++;
                assert (e.jmp && target_pc_o === e.tgt)
                    else report_value(t, "target_pc_o", e.tgt, target_pc_o);
            end
            if (advance_o) begin
                wb_ok  = wb_o.valid === e.wb.valid &&
                         (!e.wb.valid || (wb_o.rd === e.wb.rd && wb_o.data === e.wb.data));
                checks += 2;
                assert (wb_ok) else report_value(t, "wb_o", e.wb, wb_o);
                assert (jumps == int'(e.jmp)) else report_value(t, "jump pulses", e.jmp, jumps);
                commit(e);
                jumps = 0;
                retired++;
                if (retired >= 2 && (retired > prog.size() || tid[retired-1] != t)) begin
                    $display("test %-12s %s (%0d errors)", test_name[t],
                             errs[t] == 0 ? "ok" : "bad", errs[t]);
                end
                if (retired == prog.size() + 1) finished = 1'b1;
            end
            waited_m = !advance_o;
            @(negedge clk);
        end
    end

    initial begin : watchdog
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d of %0d instructions retired",
                 limit, retired, prog.size() + 1);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        valid_i   = 1'b0;
        fetch_i   = {NOP_INSTR, 32'h0};
        regs_m[0] = '0;
        build_program();
        limit = (prog.size() + 1) * 4 + 4;         // slowest case four cycles each
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait (finished);
        @(negedge clk);
        rst_n = 1'b0;                              // halt must clear
        #1;
        checks++;
        assert (halted_o === 1'b0) else begin
            $display("halted_o stayed high through reset");
            err_total++;
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, err_total);
        if (err_total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
hdl/rv_isa_pkg.sv
hdl/exec_pkg.sv
hdl/fetch_decode.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/exec_ctrl.sv
hdl/exec_top.sv
verification/tb_exec.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= vlog.f
TOP       ?= tb_exec
BUILD     ?= obj_dir
SIM_BIN   ?= sim_exec
PASS_MSG  ?= All tests passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/$(SIM_BIN): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD) -o $(SIM_BIN)

sim: $(BUILD)/$(SIM_BIN)
	@out="$$(./$(BUILD)/$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
